//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // ------------------------------------------------------------------------
    // Widths and basic types
    // ------------------------------------------------------------------------
    localparam int xlenW    = 32;    // Data and address width
    localparam int regAddrW = 5;     // Register index width
    localparam int numRegs  = 32;    // Architectural registers x0..x31

    typedef logic [xlenW-1:0]    word_t;     // Data word or byte address
    typedef logic [regAddrW-1:0] regAddr_t;  // Register index

    // Major opcodes kept in this core
    localparam logic [6:0] opOpImm = 7'b0010011;  // ADDI, SLTI, shifts ...
    localparam logic [6:0] opOp    = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] opLoad  = 7'b0000011;  // LW only
    localparam logic [6:0] opStore = 7'b0100011;  // SW only

    // ALU function select
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOp_t;

    // Source for an execute-stage operand
    typedef enum logic [1:0] {
        fwdReg,     // Value read in decode
        fwdMem,     // ALU result sitting in memory stage
        fwdWb       // Write-back word
    } fwdSel_t;

    // ------------------------------------------------------------------------
    // Decoded control and pipeline registers
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;   // Write back load data instead of ALU result
        logic   aluSrcImm;  // Operand B from immediate
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } ifId_t;

    typedef struct packed {
        ctrl_t    ctrl;     // All zero for a bubble
        regAddr_t rs1;
        regAddr_t rs2;
        regAddr_t rd;
        word_t    rs1Data;
        word_t    rs2Data;
        word_t    imm;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        regAddr_t rd;
        word_t    aluResult;  // Also the data address
        word_t    storeData;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        regAddr_t rd;
        word_t    aluResult;
        word_t    loadData;
    } memWb_t;

endpackage

`default_nettype wire

//--- design/regFile.sv
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             rst_n,
    input  cpuPkg::regAddr_t rs1,
    input  cpuPkg::regAddr_t rs2,
    input  cpuPkg::regAddr_t rd,
    input  logic             we,
    input  cpuPkg::word_t    wrData,
    output cpuPkg::word_t    rs1Data,
    output cpuPkg::word_t    rs2Data
);

    cpuPkg::word_t regs [cpuPkg::numRegs];

    // Read port with x0 and same-cycle write bypass
    function automatic cpuPkg::word_t readPort(cpuPkg::regAddr_t addr);
        if (addr == '0) return '0;
        if (we && addr == rd) return wrData;  // Write-back in flight
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpuPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin   // x0 stays zero
            regs[rd] <= wrData;
        end
    end

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

    // x0 storage must never pick up a write
    assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

`default_nettype wire

//--- design/decodeUnit.sv
`default_nettype none

module decodeUnit (
    input  cpuPkg::word_t    insn,
    output cpuPkg::ctrl_t    ctrl,
    output cpuPkg::regAddr_t rs1,
    output cpuPkg::regAddr_t rs2,
    output cpuPkg::regAddr_t rd,
    output cpuPkg::word_t    imm
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           funct7b5;   // SUB / SRA select
    cpuPkg::word_t  immI;
    cpuPkg::word_t  immS;
    cpuPkg::aluOp_t arithOp;

    // Fixed RV32I field positions
    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7b5 = insn[30];
    assign rd       = insn[11:7];
    assign rs1      = insn[19:15];
    assign rs2      = insn[24:20];

    assign immI     = {{(cpuPkg::xlenW-12){insn[31]}}, insn[31:20]};
    assign immS     = {{(cpuPkg::xlenW-12){insn[31]}}, insn[31:25], insn[11:7]};

    // ALU function from funct3 and funct7 bit 5
    always_comb begin
        case (funct3)
            3'b000: begin
                // Bit 30 selects SUB only for OP and is immediate data in ADDI
                arithOp = (opcode == cpuPkg::opOp && funct7b5) ? cpuPkg::aluSub
                                                                : cpuPkg::aluAdd;
            end
            3'b001:  arithOp = cpuPkg::aluSll;
            3'b010:  arithOp = cpuPkg::aluSlt;
            3'b011:  arithOp = cpuPkg::aluSltu;
            3'b100:  arithOp = cpuPkg::aluXor;
            3'b101:  arithOp = funct7b5 ? cpuPkg::aluSra : cpuPkg::aluSrl;
            3'b110:  arithOp = cpuPkg::aluOr;
            default: arithOp = cpuPkg::aluAnd;
        endcase
    end

    // Main control
    always_comb begin
        ctrl = '0;                  // Unknown opcode decodes as a bubble
        imm  = immI;
        case (opcode)
            cpuPkg::opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp;
            end
            cpuPkg::opOpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = arithOp;   // Shift amount sits in imm[4:0]
            end
            cpuPkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;  // Base + offset, aluAdd
            end
            cpuPkg::opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                imm            = immS;  // Split offset
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  cpuPkg::regAddr_t idRs1,
    input  cpuPkg::regAddr_t idRs2,
    input  cpuPkg::regAddr_t exRs1,
    input  cpuPkg::regAddr_t exRs2,
    input  cpuPkg::regAddr_t exRd,
    input  cpuPkg::regAddr_t memRd,
    input  cpuPkg::regAddr_t wbRd,
    input  logic             exMemRead,
    input  logic             memRegWrite,
    input  logic             wbRegWrite,
    output cpuPkg::fwdSel_t  fwdA,
    output cpuPkg::fwdSel_t  fwdB,
    output logic             stall
);

    // ------------------------------------------------------------------------
    // Forwarding from the freshest producer
    // ------------------------------------------------------------------------
    function automatic cpuPkg::fwdSel_t pickSrc(cpuPkg::regAddr_t src);
        if (src == '0) begin
            return cpuPkg::fwdReg;              // x0 is constant
        end
        if (memRegWrite && memRd == src) begin
            return cpuPkg::fwdMem;              // One instruction ahead
        end
        if (wbRegWrite && wbRd == src) begin
            return cpuPkg::fwdWb;               // Two ahead
        end
        return cpuPkg::fwdReg;
    endfunction

    always_comb begin
        fwdA = pickSrc(exRs1);
        fwdB = pickSrc(exRs2);
    end

    // ------------------------------------------------------------------------
    // Load-use detection
    // ------------------------------------------------------------------------
    // Load data only exists after the memory stage, so a consumer right
    // behind it waits one cycle and then picks the value up from write-back
    always_comb begin
        stall = exMemRead && exRd != '0 &&
                (exRd == idRs1 || exRd == idRs2);
    end

endmodule

`default_nettype wire

//--- design/alu.sv
`default_nettype none

module alu (
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    output cpuPkg::word_t  result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];                  // Only the low five bits count
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            cpuPkg::aluAdd:  result = a + b;
            cpuPkg::aluSub:  result = a - b;
            cpuPkg::aluSll:  result = a << shamt;
            cpuPkg::aluSlt:  result = {{(cpuPkg::xlenW-1){1'b0}}, ltSigned};
            cpuPkg::aluSltu: result = {{(cpuPkg::xlenW-1){1'b0}}, ltUnsigned};
            cpuPkg::aluXor:  result = a ^ b;
            cpuPkg::aluSrl:  result = a >> shamt;             // Zero fill
            cpuPkg::aluSra: begin
                // Sign fill from bit 31
                result = cpuPkg::word_t'($signed(a) >>> shamt);
            end
            cpuPkg::aluOr:   result = a | b;
            cpuPkg::aluAnd:  result = a & b;
            default:         result = '0;                     // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpuCore.sv
`default_nettype none

module cpuCore (
    input  logic          clk,
    input  logic          rst_n,
    input  cpuPkg::word_t imemInsn,
    input  cpuPkg::word_t dmemRdData,
    output cpuPkg::word_t imemAddr,
    output cpuPkg::word_t dmemAddr,
    output cpuPkg::word_t dmemWrData,
    output logic          dmemWen
);

    cpuPkg::word_t    pc;
    cpuPkg::ifId_t    ifId;
    cpuPkg::idEx_t    idEx;
    cpuPkg::exMem_t   exMem;
    cpuPkg::memWb_t   memWb;

    cpuPkg::ctrl_t    decCtrl;     // Raw decode
    cpuPkg::ctrl_t    idCtrl;      // After bubble insertion
    cpuPkg::regAddr_t decRs1;
    cpuPkg::regAddr_t decRs2;
    cpuPkg::regAddr_t decRd;
    cpuPkg::word_t    decImm;
    cpuPkg::word_t    rs1Data;
    cpuPkg::word_t    rs2Data;

    logic             stall;
    cpuPkg::fwdSel_t  fwdA;
    cpuPkg::fwdSel_t  fwdB;
    cpuPkg::word_t    opA;
    cpuPkg::word_t    opB;         // Forwarded rs2, also the store data
    cpuPkg::word_t    aluB;
    cpuPkg::word_t    aluResult;
    cpuPkg::word_t    wbData;

    // ------------------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------------------
    assign imemAddr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!stall) begin  // Load-use holds PC and fetch register
            pc   <= pc + 32'd4;
            ifId <= '{valid: 1'b1, pc: pc, insn: imemInsn};
        end
    end

    // ------------------------------------------------------------------------
    // Decode and register read
    // ------------------------------------------------------------------------
    decodeUnit uDecode (
        .insn (ifId.insn),
        .ctrl (decCtrl),
        .rs1  (decRs1),
        .rs2  (decRs2),
        .rd   (decRd),
        .imm  (decImm)
    );

    regFile uRegFile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (decRs1),
        .rs2     (decRs2),
        .rd      (memWb.rd),
        .we      (memWb.regWrite),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    hazardUnit uHazard (
        .idRs1       (decRs1),
        .idRs2       (decRs2),
        .exRs1       (idEx.rs1),
        .exRs2       (idEx.rs2),
        .exRd        (idEx.rd),
        .memRd       (exMem.rd),
        .wbRd        (memWb.rd),
        .exMemRead   (idEx.ctrl.memRead),
        .memRegWrite (exMem.regWrite),
        .wbRegWrite  (memWb.regWrite),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall)
    );

    always_comb begin
        idCtrl = decCtrl;
        if (!ifId.valid || stall) begin
            idCtrl = '0;            // Bubble into execute
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else begin
            idEx <= '{ctrl: idCtrl, rs1: decRs1, rs2: decRs2, rd: decRd,
                      rs1Data: rs1Data, rs2Data: rs2Data, imm: decImm};
        end
    end

    // ------------------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------------------
    function automatic cpuPkg::word_t fwdMux(cpuPkg::fwdSel_t sel,
                                             cpuPkg::word_t regVal);
        case (sel)
            cpuPkg::fwdMem: return exMem.aluResult;
            cpuPkg::fwdWb:  return wbData;
            default:        return regVal;
        endcase
    endfunction

    always_comb begin
        opA  = fwdMux(fwdA, idEx.rs1Data);
        opB  = fwdMux(fwdB, idEx.rs2Data);
        aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;
    end

    alu uAlu (
        .op     (idEx.ctrl.aluOp),
        .a      (opA),
        .b      (aluB),
        .result (aluResult)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else begin
            exMem <= '{regWrite: idEx.ctrl.regWrite, memRead: idEx.ctrl.memRead,
                       memWrite: idEx.ctrl.memWrite, memToReg: idEx.ctrl.memToReg,
                       rd: idEx.rd, aluResult: aluResult, storeData: opB};
        end
    end

    // ------------------------------------------------------------------------
    // Memory access and write-back
    // ------------------------------------------------------------------------
    assign dmemAddr   = exMem.aluResult;
    assign dmemWrData = exMem.storeData;
    assign dmemWen    = exMem.memWrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else begin
            memWb <= '{regWrite: exMem.regWrite, memToReg: exMem.memToReg,
                       rd: exMem.rd, aluResult: exMem.aluResult,
                       loadData: dmemRdData};
        end
    end

    assign wbData = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    // A single instruction never both loads and stores
    assert property (@(posedge clk) disable iff (!rst_n)
        !(dmemWen && exMem.memRead));

    // Bubble behind the load clears the hazard on the next cycle
    assert property (@(posedge clk) disable iff (!rst_n) stall |=> !stall);

    // No fetch is skipped or repeated across a stall
    assert property (@(posedge clk) disable iff (!rst_n)
        ifId.valid && !stall |=> ifId.pc == $past(ifId.pc) + 32'd4);

endmodule

`default_nettype wire

//--- verification/cpuChecker.sv
`default_nettype none

module cpuChecker (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          progReady,
    input  cpuPkg::word_t progMem [256],
    input  cpuPkg::word_t imemAddr,
    input  logic          dmemWen,
    input  cpuPkg::word_t dmemAddr,
    input  cpuPkg::word_t dmemWrData,
    output int            mismatchErrs,
    output int            extraErrs,
    output int            pending,     // Expected stores not yet seen
    output logic          allSeen
);

    typedef struct packed {
        cpuPkg::word_t addr;
        cpuPkg::word_t data;
    } store_t;

    cpuPkg::word_t refRegs [32];       // Architectural model state
    cpuPkg::word_t refMem  [64];
    store_t        expQ    [$];        // Stores in program order

    // ------------------------------------------------------------------------
    // Reference model executing one instruction per call
    // ------------------------------------------------------------------------
    function automatic void execInsn(cpuPkg::word_t insn);
        logic [6:0]    opcode;
        logic [2:0]    f3;
        logic [4:0]    rd;
        logic [4:0]    rs1;
        logic [4:0]    rs2;
        logic [4:0]    sh;
        logic          lt;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t immI;
        cpuPkg::word_t immS;
        cpuPkg::word_t r;
        cpuPkg::word_t addr;

        opcode = insn[6:0];
        f3     = insn[14:12];
        rd     = insn[11:7];
        rs1    = insn[19:15];
        rs2    = insn[24:20];
        immI   = {{20{insn[31]}}, insn[31:20]};
        immS   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        a      = refRegs[rs1];                      // Entry 0 is never written
        b      = (opcode == cpuPkg::opOp) ? refRegs[rs2] : immI;
        sh     = b[4:0];                            // Shift amount from the low five bits
        r      = '0;

        case (opcode)
            cpuPkg::opOp, cpuPkg::opOpImm: begin
                case (f3)
                    3'b000:  r = (opcode == cpuPkg::opOp && insn[30]) ? a - b : a + b;
                    3'b001:  r = a << sh;
                    3'b010: begin
                        // With differing signs the negative one is smaller
                        lt = (a[31] != b[31]) ? a[31] : (a < b);
                        r  = {31'b0, lt};
                    end
                    3'b011:  r = {31'b0, a < b};
                    3'b100:  r = a ^ b;
                    3'b101: begin
                        r = a >> sh;
                        if (insn[30] && a[31]) begin
                            r = r | ~(32'hFFFF_FFFF >> sh);  // Sign fill
                        end
                    end
                    3'b110:  r = a | b;
                    default: r = a & b;
                endcase
                if (rd != 5'd0) begin
                    refRegs[rd] = r;
                end
            end
            cpuPkg::opLoad: begin
                addr = a + immI;
                if (rd != 5'd0) begin
                    refRegs[rd] = refMem[addr[7:2]];
                end
            end
            cpuPkg::opStore: begin
                addr = a + immS;
                refMem[addr[7:2]] = refRegs[rs2];
                expQ.push_back('{addr: addr, data: refRegs[rs2]});
            end
            default: ;                              // No state change for other opcodes
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Store and fetch comparison
    // ------------------------------------------------------------------------
    initial begin : compareStores
        store_t        want;
        cpuPkg::word_t prevFetch;                   // Fetch address one cycle back
        logic          fetchHeld;                   // Previous cycle repeated its address

        mismatchErrs = 0;
        extraErrs    = 0;
        pending     <= 0;
        allSeen     <= 1'b0;
        prevFetch    = 32'hFFFF_FFFC;
        fetchHeld    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            refMem[i] = '0;
        end

        wait (progReady);                           // Program array filled
        for (int i = 0; i < $size(progMem); i++) begin
            execInsn(progMem[i]);
        end
        pending <= expQ.size();

        forever begin
            @(posedge clk);

            // PC starts at zero, advances by one word, holds for one stall cycle
            if (!rst_n) begin
                prevFetch = 32'hFFFF_FFFC;
                fetchHeld = 1'b0;
            end else if (imemAddr == prevFetch + 32'd4) begin
                prevFetch = imemAddr;
                fetchHeld = 1'b0;
            end else if (imemAddr == prevFetch && !fetchHeld) begin
                fetchHeld = 1'b1;                   // Load-use stall
            end else begin
                $display("Mismatch imemAddr: got %h, expected %h",
                         imemAddr, prevFetch + 32'd4);
                mismatchErrs++;
                prevFetch = imemAddr;
                fetchHeld = 1'b0;
            end

            if (dmemWen) begin
                if (!rst_n) begin
                    $display("Store to %h seen while reset is still asserted", dmemAddr);
                    extraErrs++;
                end else if (expQ.size() == 0) begin
                    $display("Extra store to %h with data %h after the expected sequence",
                             dmemAddr, dmemWrData);
                    extraErrs++;
                end else begin
                    want = expQ.pop_front();
                    if (dmemAddr !== want.addr) begin
                        $display("Mismatch dmemAddr: got %h, expected %h",
                                 dmemAddr, want.addr);
                        mismatchErrs++;
                    end
                    if (dmemWrData !== want.data) begin
                        $display("Mismatch dmemWrData: got %h, expected %h",
                                 dmemWrData, want.data);
                        mismatchErrs++;
                    end
                end
            end
            pending <= expQ.size();
            allSeen <= (expQ.size() == 0);          // Settles after this edge
        end
    end

endmodule

`default_nettype wire

//--- verification/cpuTb.sv
`default_nettype none

module cpuTb;

    localparam int            progWords = 256;            // Program array size
    localparam int            progLen   = 200;            // Generated instructions
    localparam int            maxCycles = 2 * progLen + 50;
    localparam int            drvDelay  = 2;              // Skew after rising edge
    localparam cpuPkg::word_t nopInsn   = 32'h0000_0013;  // addi x0, x0, 0

    logic          clk;
    logic          rst_n;
    cpuPkg::word_t imemInsn;
    cpuPkg::word_t dmemRdData;
    cpuPkg::word_t imemAddr;
    cpuPkg::word_t dmemAddr;
    cpuPkg::word_t dmemWrData;
    logic          dmemWen;

    cpuPkg::word_t progMem [progWords];
    cpuPkg::word_t dmem    [64];
    logic          progReady;
    logic [31:0]   lfsrState;
    int            progCount;
    cpuPkg::word_t lastRd;                    // Destination of the last ALU op

    int            mismatchErrs;
    int            extraErrs;
    int            pending;
    logic          allSeen;
    int            cycles;
    logic          timedOut;

    cpuCore UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imemInsn   (imemInsn),
        .dmemRdData (dmemRdData),
        .imemAddr   (imemAddr),
        .dmemAddr   (dmemAddr),
        .dmemWrData (dmemWrData),
        .dmemWen    (dmemWen)
    );

    cpuChecker storeCheck (
        .clk          (clk),
        .rst_n        (rst_n),
        .progReady    (progReady),
        .progMem      (progMem),
        .imemAddr     (imemAddr),
        .dmemWen      (dmemWen),
        .dmemAddr     (dmemAddr),
        .dmemWrData   (dmemWrData),
        .mismatchErrs (mismatchErrs),
        .extraErrs    (extraErrs),
        .pending      (pending),
        .allSeen      (allSeen)
    );

    // ------------------------------------------------------------------------
    // Random bits and instruction encoding
    // ------------------------------------------------------------------------
    function automatic logic [31:0] nextLfsr(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    function automatic cpuPkg::word_t randBits(int n);
        cpuPkg::word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);     // One step per bit
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic cpuPkg::word_t nonZeroReg();
        cpuPkg::word_t r;
        r = randBits(3);
        return (r == '0) ? 32'd1 : r;
    endfunction

    function automatic cpuPkg::word_t encodeR(cpuPkg::word_t f7, cpuPkg::word_t rs2,
                                              cpuPkg::word_t rs1, cpuPkg::word_t f3,
                                              cpuPkg::word_t rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], cpuPkg::opOp};
    endfunction

    function automatic cpuPkg::word_t encodeI(cpuPkg::word_t imm, cpuPkg::word_t rs1,
                                              cpuPkg::word_t f3, cpuPkg::word_t rd,
                                              logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic cpuPkg::word_t encodeS(cpuPkg::word_t imm, cpuPkg::word_t rs2,
                                              cpuPkg::word_t rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], cpuPkg::opStore};
    endfunction

    task automatic emit(cpuPkg::word_t insn);
        progMem[progCount] = insn;
        progCount++;
    endtask

    task automatic genAluR(cpuPkg::word_t rd, cpuPkg::word_t rs1);
        cpuPkg::word_t f3;
        cpuPkg::word_t f7;
        f3 = randBits(3);
        f7 = '0;
        if (f3[2:0] == 3'b000 || f3[2:0] == 3'b101) begin
            f7 = randBits(1) << 5;               // SUB or SRA
        end
        emit(encodeR(f7, randBits(3), rs1, f3, rd));
    endtask

    task automatic genAluI(cpuPkg::word_t rd, cpuPkg::word_t rs1);
        cpuPkg::word_t f3;
        cpuPkg::word_t imm;
        f3 = randBits(3);
        case (f3[2:0])
            3'b001:  imm = randBits(5);          // SLLI
            3'b101: begin
                imm = randBits(5);
                imm = imm | (randBits(1) << 10); // SRAI when set
            end
            default: imm = randBits(12);         // Full signed range
        endcase
        emit(encodeI(imm, rs1, f3, rd, cpuPkg::opOpImm));
    endtask

    task automatic genProgram();
        cpuPkg::word_t kind;
        cpuPkg::word_t src;
        cpuPkg::word_t dst;
        lfsrState = 32'd85474;
        progCount = 0;
        lastRd    = '0;
        for (int i = 0; i < progWords; i++) begin
            progMem[i] = nopInsn;
        end
        while (progCount < progLen - 8) begin
            kind = randBits(3);
            dst  = randBits(3);                  // x0 now and then
            src  = randBits(1) ? lastRd : randBits(3);  // Often the newest result
            case (kind[2:0])
                3'b000, 3'b001, 3'b010: begin
                    genAluR(dst, src);
                    lastRd = dst;
                end
                3'b011, 3'b100: begin
                    genAluI(dst, src);
                    lastRd = dst;
                end
                3'b101: begin
                    emit(encodeI(randBits(6) << 2, '0, 32'd2, dst, cpuPkg::opLoad));
                    lastRd = dst;
                end
                3'b110: emit(encodeS(randBits(6) << 2, src, '0));
                default: begin
                    // Load-use pair
                    dst = nonZeroReg();
                    emit(encodeI(randBits(6) << 2, '0, 32'd2, dst, cpuPkg::opLoad));
                    src = randBits(3);
                    genAluR(src, dst);
                    lastRd = src;
                end
            endcase
        end
        for (int r = 1; r < 8; r++) begin
            emit(encodeS(cpuPkg::word_t'(4 * r), cpuPkg::word_t'(r), '0));  // Final dump
        end
    endtask

    // ------------------------------------------------------------------------
    // Clock, memories and run control
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : memModel
        cpuPkg::word_t idx;
        imemInsn   = nopInsn;
        dmemRdData = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = '0;
        end
        forever begin
            @(posedge clk);
            if (dmemWen) begin
                dmem[dmemAddr[7:2]] = dmemWrData;  // Write strobe at the edge
            end
            #drvDelay;
            idx        = imemAddr >> 2;
            imemInsn   = (idx < progWords) ? progMem[idx[7:0]] : nopInsn;
            dmemRdData = dmem[dmemAddr[7:2]];
        end
    end

    initial begin : runControl
        rst_n     = 1'b0;
        progReady = 1'b0;
        timedOut  = 1'b0;
        cycles    = 0;
        genProgram();
        progReady = 1'b1;
        repeat (5) @(posedge clk);
        #drvDelay;
        rst_n = 1'b1;

        while (!allSeen && cycles < maxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!allSeen) begin
            timedOut = 1'b1;
            $display("Run timed out after %0d cycles with %0d stores still expected",
                     cycles, pending);
        end else begin
            repeat (10) @(posedge clk);          // Stray stores after the last one
        end

        $display("Errors: %0d mismatch, %0d extra store, %0d missing store",
                 mismatchErrs, extraErrs, pending);
        if (timedOut || mismatchErrs + extraErrs + pending != 0) begin
            $display("Something failed");
        end else begin
            $display("Everything OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/cpuPkg.sv
design/regFile.sv
design/decodeUnit.sv
design/hazardUnit.sv
design/alu.sv
design/cpuCore.sv
verification/cpuChecker.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= compile.f
PASSMSG   ?= Everything OK

SRCS := $(wildcard design/*.sv verification/*.sv)
BIN  := $(MDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(MDIR)
